// File: compile.f
+incdir+include
rtl/fight_pkg.sv
rtl/frame_tick_gen.sv
rtl/cpu_opponent.sv
rtl/player.sv
rtl/hit_detect.sv
rtl/health_status.sv
rtl/fight_core.sv
verif/fight_core_tb.sv

// File: include/fight_defs.svh
`ifndef FIGHT_DEFS_SVH
`define FIGHT_DEFS_SVH

// ==========================================================================
// Frame timing
// ==========================================================================
`define FRAME_DIV       4          // clk cycles per game frame, short for simulation

// ==========================================================================
// Arena and box geometry, all in pixels along the floor
// ==========================================================================
`define ARENA_W         640        // Visible arena width
`define BODY_W          40         // Body box width
`define REACH_PX        30         // Strike box width in front of the body
`define STEP_PX         4          // Walk distance per frame
`define P1_START_X      100        // Player 1 spawn
`define P2_START_X      500        // Player 2 spawn

// ==========================================================================
// Attack and damage timing, in frames
// ==========================================================================
`define WINDUP_FRAMES   3          // Before the strike box is live
`define ACTIVE_FRAMES   2          // Strike box live
`define RECOVER_FRAMES  4          // Cool-down after the strike
`define HITSTUN_FRAMES  6          // Stagger after taking a hit
`define MAX_HEALTH      5          // Hits to knockout
`define LFSR_SEED       16'hACE1   // Any nonzero value

`endif

// File: rtl/cpu_opponent.sv
`timescale 1ns/1ps
`default_nettype none

`include "fight_defs.svh"

module cpu_opponent import fight_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic frame_tick,
  input  logic cpu_mode,             // High lets the LFSR play player 2
  input  logic pad_left,
  input  logic pad_right,
  input  logic pad_attack,
  output logic left,
  output logic right,
  output logic attack
);

  lfsr_t lfsr;                       // Fibonacci LFSR, shifts toward the MSB
  logic  feedback;

  assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // Maximal-length taps

  always_ff @(posedge clk) begin
    if (reset) begin
      lfsr <= `LFSR_SEED;
    end else if (frame_tick) begin
      lfsr <= {lfsr[14:0], feedback};  // One step per frame
    end
  end

  // Attack needs two bits set so the CPU swings about a quarter of the time
  assign left   = cpu_mode ? lfsr[0] : pad_left;
  assign right  = cpu_mode ? lfsr[1] : pad_right;
  assign attack = cpu_mode ? (lfsr[2] & lfsr[3]) : pad_attack;

endmodule

`default_nettype wire

// File: rtl/fight_core.sv
`timescale 1ns/1ps
`default_nettype none

module fight_core import fight_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          p1_left,
  input  logic          p1_right,
  input  logic          p1_attack,
  input  logic          p2_left,
  input  logic          p2_right,
  input  logic          p2_attack,
  input  logic          cpu_mode,        // Random player 2 when high
  output coord_t        p1_x,
  output coord_t        p2_x,
  output player_state_t p1_state,
  output player_state_t p2_state,
  output health_t       p1_health,
  output health_t       p2_health,
  output logic          round_over
);

  // ==========================================================================
  // Internal nets
  // ==========================================================================
  logic   frame_tick;                    // Game frame enable
  logic   p2_left_eff;                   // Pad or CPU controls for player 2
  logic   p2_right_eff;
  logic   p2_attack_eff;
  coord_t p1_body_lo, p1_body_hi, p1_strike_lo, p1_strike_hi;
  coord_t p2_body_lo, p2_body_hi, p2_strike_lo, p2_strike_hi;
  logic   p1_hit, p2_hit;                // From hit detection
  logic   p1_ko, p2_ko;                  // From health tracking

  frame_tick_gen tick_gen_inst (.clk(clk), .reset(reset), .frame_tick(frame_tick));

  cpu_opponent cpu_inst (
    .clk(clk), .reset(reset), .frame_tick(frame_tick), .cpu_mode(cpu_mode),
    .pad_left(p2_left), .pad_right(p2_right), .pad_attack(p2_attack),
    .left(p2_left_eff), .right(p2_right_eff), .attack(p2_attack_eff)
  );

  player #(.SIDE(1'b0)) player1 (
    .clk(clk), .reset(reset), .frame_tick(frame_tick),
    .left(p1_left), .right(p1_right), .attack(p1_attack),
    .hit(p1_hit), .ko(p1_ko),
    .x(p1_x), .state(p1_state),
    .body_lo(p1_body_lo), .body_hi(p1_body_hi),
    .strike_lo(p1_strike_lo), .strike_hi(p1_strike_hi)
  );

  player #(.SIDE(1'b1)) player2 (
    .clk(clk), .reset(reset), .frame_tick(frame_tick),
    .left(p2_left_eff), .right(p2_right_eff), .attack(p2_attack_eff),
    .hit(p2_hit), .ko(p2_ko),
    .x(p2_x), .state(p2_state),
    .body_lo(p2_body_lo), .body_hi(p2_body_hi),
    .strike_lo(p2_strike_lo), .strike_hi(p2_strike_hi)
  );

  hit_detect hit_detect_inst (
    .clk(clk), .reset(reset), .frame_tick(frame_tick),
    .p1_state(p1_state), .p1_body_lo(p1_body_lo), .p1_body_hi(p1_body_hi),
    .p1_strike_lo(p1_strike_lo), .p1_strike_hi(p1_strike_hi),
    .p2_state(p2_state), .p2_body_lo(p2_body_lo), .p2_body_hi(p2_body_hi),
    .p2_strike_lo(p2_strike_lo), .p2_strike_hi(p2_strike_hi),
    .p1_hit(p1_hit), .p2_hit(p2_hit)
  );

  health_status health_status_inst (
    .clk(clk), .reset(reset), .frame_tick(frame_tick),
    .p1_hit(p1_hit), .p2_hit(p2_hit),
    .p1_health(p1_health), .p2_health(p2_health),
    .p1_ko(p1_ko), .p2_ko(p2_ko), .round_over(round_over)
  );

endmodule

`default_nettype wire

// File: rtl/fight_pkg.sv
`default_nettype none

package fight_pkg;

  // ==========================================================================
  // Quantities with a meaning of their own
  // ==========================================================================
  typedef logic [9:0]  coord_t;      // Pixel x position, covers 0..1023
  typedef logic [2:0]  health_t;     // Health points left
  typedef logic [3:0]  frame_cnt_t;  // Frames left in a timed state
  typedef logic [15:0] lfsr_t;       // CPU opponent random register

  // ==========================================================================
  // Player FSM
  // ==========================================================================
  // Encoding matches the sprite state numbering of the board build
  typedef enum logic [3:0] {
    ST_IDLE    = 4'd0,   // Standing
    ST_WALK    = 4'd1,   // Moving one step per frame
    ST_WINDUP  = 4'd2,   // Attack started, no strike box yet
    ST_ACTIVE  = 4'd3,   // Strike box can land
    ST_RECOVER = 4'd4,   // Attack finished, still locked
    ST_HITSTUN = 4'd5,   // Staggered by a hit
    ST_KO      = 4'd6    // Out of health, final
  } player_state_t;

endpackage

`default_nettype wire

// File: rtl/frame_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fight_defs.svh"

module frame_tick_gen (
  input  logic clk,
  input  logic reset,
  output logic frame_tick            // One clk cycle wide, once per frame
);

  localparam int CNT_W = ($clog2(`FRAME_DIV) < 1) ? 1 : $clog2(`FRAME_DIV);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`FRAME_DIV - 1);

  logic [CNT_W-1:0] cnt;             // Cycles into the current frame

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (cnt == LAST) begin
      cnt <= '0;                     // Wrap at frame end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Enable pulse replaces the old derived game clock
  assign frame_tick = (cnt == LAST);

  // Every block relies on a single-cycle enable
  a_tick_single : assert property (@(posedge clk) disable iff (reset)
    frame_tick |=> !frame_tick);

endmodule

`default_nettype wire

// File: rtl/health_status.sv
`timescale 1ns/1ps
`default_nettype none

`include "fight_defs.svh"

module health_status import fight_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    frame_tick,
  input  logic    p1_hit,
  input  logic    p2_hit,
  output health_t p1_health,
  output health_t p2_health,
  output logic    p1_ko,
  output logic    p2_ko,
  output logic    round_over             // Either side knocked out
);

  localparam health_t FULL = health_t'(`MAX_HEALTH);

  // ==========================================================================
  // Health counters, one point per hit, floored at zero
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      p1_health <= FULL;
      p2_health <= FULL;
    end else if (frame_tick) begin
      if (p1_hit && p1_health != '0) begin
        p1_health <= p1_health - 1'b1;
      end
      if (p2_hit && p2_health != '0) begin
        p2_health <= p2_health - 1'b1;
      end
    end
  end

  assign p1_ko      = (p1_health == '0);     // Seen by the player on the next tick
  assign p2_ko      = (p2_health == '0);
  assign round_over = p1_ko | p2_ko;

  // Only reset refills health
  a_health_monotonic : assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> (p1_health <= $past(p1_health)) &&
                      (p2_health <= $past(p2_health)));

endmodule

`default_nettype wire

// File: rtl/hit_detect.sv
`timescale 1ns/1ps
`default_nettype none

module hit_detect import fight_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          frame_tick,
  input  player_state_t p1_state,
  input  coord_t        p1_body_lo,
  input  coord_t        p1_body_hi,
  input  coord_t        p1_strike_lo,
  input  coord_t        p1_strike_hi,
  input  player_state_t p2_state,
  input  coord_t        p2_body_lo,
  input  coord_t        p2_body_hi,
  input  coord_t        p2_strike_lo,
  input  coord_t        p2_strike_hi,
  output logic          p1_hit,          // Player 1 was struck, held one frame
  output logic          p2_hit           // Player 2 was struck, held one frame
);

  logic p1_hit_nxt;
  logic p2_hit_nxt;

  // Inclusive interval overlap along the floor
  function automatic logic overlap(input coord_t a_lo, input coord_t a_hi,
                                   input coord_t b_lo, input coord_t b_hi);
    return (a_lo <= b_hi) && (b_lo <= a_hi);
  endfunction

  // Staggered or knocked-out defenders take no damage
  function automatic logic can_be_hit(input player_state_t s);
    return (s != ST_HITSTUN) && (s != ST_KO);
  endfunction

  // Own flag blocks a second hit from the same strike window
  assign p2_hit_nxt = (p1_state == ST_ACTIVE) && can_be_hit(p2_state) && !p2_hit &&
                      overlap(p1_strike_lo, p1_strike_hi, p2_body_lo, p2_body_hi);
  assign p1_hit_nxt = (p2_state == ST_ACTIVE) && can_be_hit(p1_state) && !p1_hit &&
                      overlap(p2_strike_lo, p2_strike_hi, p1_body_lo, p1_body_hi);

  always_ff @(posedge clk) begin
    if (reset) begin
      p1_hit <= 1'b0;
      p2_hit <= 1'b0;
    end else if (frame_tick) begin
      p1_hit <= p1_hit_nxt;                // Boxes as they stood before this tick
      p2_hit <= p2_hit_nxt;
    end
  end

  // Knockout must come after the hit that caused it, never with a fresh one
  a_no_hit_on_ko : assert property (@(posedge clk) disable iff (reset)
    (p1_hit |-> p1_state != ST_KO) and (p2_hit |-> p2_state != ST_KO));

endmodule

`default_nettype wire

// File: rtl/player.sv
`timescale 1ns/1ps
`default_nettype none

`include "fight_defs.svh"

module player import fight_pkg::*; #(
  parameter bit SIDE = 1'b0              // 0 faces right, 1 faces left
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          frame_tick,
  input  logic          left,
  input  logic          right,
  input  logic          attack,
  input  logic          hit,             // Landed on us last frame
  input  logic          ko,              // Health is gone
  output coord_t        x,               // Left edge of the body
  output player_state_t state,
  output coord_t        body_lo,
  output coord_t        body_hi,
  output coord_t        strike_lo,
  output coord_t        strike_hi
);

  localparam coord_t START_X = SIDE ? coord_t'(`P2_START_X) : coord_t'(`P1_START_X);
  localparam coord_t MAX_X   = coord_t'(`ARENA_W - `BODY_W);  // Right wall for the body
  localparam coord_t STEP    = coord_t'(`STEP_PX);
  localparam coord_t BODY_W  = coord_t'(`BODY_W);
  localparam coord_t REACH   = coord_t'(`REACH_PX);

  player_state_t state_nxt;
  coord_t        x_nxt;
  frame_cnt_t    cnt;                    // Frames left in the timed state, minus one
  frame_cnt_t    cnt_nxt;
  logic          phase_done;             // Last frame of a timed state

  assign phase_done = (cnt == '0);

  // ==========================================================================
  // Next-state logic, evaluated for the coming frame tick
  // ==========================================================================
  always_comb begin
    state_nxt = state;
    x_nxt     = x;
    cnt_nxt   = cnt;
    if (ko || state == ST_KO) begin
      state_nxt = ST_KO;                 // Knockout is final
    end else if (hit) begin
      state_nxt = ST_HITSTUN;            // Hit interrupts anything, even a strike
      cnt_nxt   = frame_cnt_t'(`HITSTUN_FRAMES - 1);
    end else begin
      case (state)
        ST_IDLE, ST_WALK: begin
          if (attack) begin
            state_nxt = ST_WINDUP;       // Attack beats movement
            cnt_nxt   = frame_cnt_t'(`WINDUP_FRAMES - 1);
          end else if (left ^ right) begin
            state_nxt = ST_WALK;
            if (left) begin
              x_nxt = (x < STEP) ? '0 : x - STEP;             // Clamp at left wall
            end else begin
              x_nxt = (x > MAX_X - STEP) ? MAX_X : x + STEP;  // Clamp at right wall
            end
          end else begin
            state_nxt = ST_IDLE;         // No input or both directions
          end
        end
        ST_WINDUP: begin
          if (phase_done) begin
            state_nxt = ST_ACTIVE;
            cnt_nxt   = frame_cnt_t'(`ACTIVE_FRAMES - 1);
          end else begin
            cnt_nxt = cnt - 1'b1;
          end
        end
        ST_ACTIVE: begin
          if (phase_done) begin
            state_nxt = ST_RECOVER;
            cnt_nxt   = frame_cnt_t'(`RECOVER_FRAMES - 1);
          end else begin
            cnt_nxt = cnt - 1'b1;
          end
        end
        ST_RECOVER, ST_HITSTUN: begin
          if (phase_done) begin
            state_nxt = ST_IDLE;         // Back under player control
          end else begin
            cnt_nxt = cnt - 1'b1;
          end
        end
        default: begin
          state_nxt = ST_IDLE;           // Unused encodings recover
        end
      endcase
    end
  end

  // ==========================================================================
  // Frame registers
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      x     <= START_X;
      cnt   <= '0;
    end else if (frame_tick) begin
      state <= state_nxt;
      x     <= x_nxt;
      cnt   <= cnt_nxt;
    end
  end

  // Body box follows x, inclusive edges
  assign body_lo = x;
  assign body_hi = x + BODY_W - 1'b1;

  // Strike box sits right in front of the body
  // Facing left at x = 0 leaves a single pixel instead of a wrapped edge
  assign strike_lo = SIDE ? ((x < REACH) ? '0 : x - REACH)
                          : x + BODY_W;
  assign strike_hi = SIDE ? ((x == '0) ? '0 : x - 1'b1)
                          : x + BODY_W + REACH - 1'b1;

endmodule

`default_nettype wire

// File: verif/fight_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fight_defs.svh"

module fight_core_tb import fight_pkg::*; ();

  localparam logic [2:0] NONE  = 3'b000;     // Pad codes {attack, right, left}
  localparam logic [2:0] LEFT  = 3'b001;
  localparam logic [2:0] RIGHT = 3'b010;
  localparam logic [2:0] BOTH  = 3'b011;
  localparam logic [2:0] ATK   = 3'b100;
  localparam int DIRECTED_FRAMES = 220;      // Sum of the scripted segments
  localparam int RANDOM_FRAMES   = 300;
  localparam int TIMEOUT_CYCLES  = (DIRECTED_FRAMES + RANDOM_FRAMES + 50) * `FRAME_DIV;

  logic clk = 1'b0;
  logic reset, cpu_mode;
  logic p1_left, p1_right, p1_attack, p2_left, p2_right, p2_attack;
  coord_t        p1_x, p2_x;
  player_state_t p1_state, p2_state;
  health_t       p1_health, p2_health;
  logic          round_over;

  logic       stim_done   = 1'b0;            // Last frame has been sampled
  logic       saw_hitstun = 1'b0;            // Scenario milestones
  logic       saw_ko      = 1'b0;
  logic       saw_p1_stun = 1'b0;
  int         cycle_count = 0;
  logic [2:0] cap_p1, cap_p2;                // Inputs seen by the coming tick
  logic       cap_cpu;

  // Frame-level model state, index 0 is player 1
  player_state_t m_state [2];
  int            m_x [2];
  int            m_age [2];                  // Frames spent in a timed state
  int            m_health [2];
  logic          m_hit [2];                  // Hit flag against this player
  lfsr_t         m_lfsr;

  always #4 clk = ~clk;                      // 8 ns period

  fight_core dut0 (
    .clk(clk), .reset(reset),
    .p1_left(p1_left), .p1_right(p1_right), .p1_attack(p1_attack),
    .p2_left(p2_left), .p2_right(p2_right), .p2_attack(p2_attack),
    .cpu_mode(cpu_mode),
    .p1_x(p1_x), .p2_x(p2_x), .p1_state(p1_state), .p2_state(p2_state),
    .p1_health(p1_health), .p2_health(p2_health), .round_over(round_over)
  );

  // ==========================================================================
  // Reference model
  // ==========================================================================
  function automatic int phase_len(input player_state_t s);
    case (s)
      ST_WINDUP:  return `WINDUP_FRAMES;
      ST_ACTIVE:  return `ACTIVE_FRAMES;
      ST_RECOVER: return `RECOVER_FRAMES;
      default:    return `HITSTUN_FRAMES;
    endcase
  endfunction

  function automatic player_state_t phase_next(input player_state_t s);
    if (s == ST_WINDUP) return ST_ACTIVE;
    if (s == ST_ACTIVE) return ST_RECOVER;
    return ST_IDLE;                          // Recovery and stun end standing
  endfunction

  // Strike box edges, player 1 reaches right and player 2 reaches left
  function automatic int strike_lo_of(input int side, input int x);
    if (side == 0) return x + `BODY_W;
    return (x - `REACH_PX < 0) ? 0 : x - `REACH_PX;
  endfunction

  function automatic int strike_hi_of(input int side, input int x);
    if (side == 0) return x + `BODY_W + `REACH_PX - 1;
    return (x - 1 < 0) ? 0 : x - 1;
  endfunction

  function automatic void model_reset();
    m_x[0] = `P1_START_X;
    m_x[1] = `P2_START_X;
    for (int i = 0; i < 2; i++) begin
      m_state[i]  = ST_IDLE;
      m_age[i]    = 0;
      m_health[i] = `MAX_HEALTH;
      m_hit[i]    = 1'b0;
    end
    m_lfsr = `LFSR_SEED;
  endfunction

  // One frame tick, every rule reads the values from before the tick
  function automatic void model_frame(input logic [2:0] pad1, input logic [2:0] pad2,
                                      input logic cpu);
    logic [2:0] ctl [2];
    logic       hit_new [2];
    int         att;
    int         nx;
    ctl[0] = pad1;
    ctl[1] = cpu ? {m_lfsr[2] & m_lfsr[3], m_lfsr[1], m_lfsr[0]} : pad2;
    for (int i = 0; i < 2; i++) begin
      att = 1 - i;                           // Opponent is the attacker
      hit_new[i] = (m_state[att] == ST_ACTIVE) &&
                   (strike_lo_of(att, m_x[att]) <= m_x[i] + `BODY_W - 1) &&
                   (m_x[i] <= strike_hi_of(att, m_x[att])) &&
                   (m_state[i] != ST_HITSTUN) && (m_state[i] != ST_KO) && !m_hit[i];
    end
    for (int i = 0; i < 2; i++) begin
      if (m_health[i] == 0 || m_state[i] == ST_KO) begin
        m_state[i] = ST_KO;                  // Knockout holds forever
      end else if (m_hit[i]) begin
        m_state[i] = ST_HITSTUN;
        m_age[i]   = 1;
      end else if (m_state[i] == ST_IDLE || m_state[i] == ST_WALK) begin
        if (ctl[i][2]) begin
          m_state[i] = ST_WINDUP;
          m_age[i]   = 1;
        end else if (ctl[i][0] != ctl[i][1]) begin
          m_state[i] = ST_WALK;
          nx = m_x[i] + (ctl[i][1] ? `STEP_PX : -`STEP_PX);
          if (nx < 0) nx = 0;
          if (nx > `ARENA_W - `BODY_W) nx = `ARENA_W - `BODY_W;
          m_x[i] = nx;
        end else begin
          m_state[i] = ST_IDLE;
        end
      end else if (m_age[i] >= phase_len(m_state[i])) begin
        m_state[i] = phase_next(m_state[i]);
        m_age[i]   = 1;
      end else begin
        m_age[i]++;
      end
    end
    for (int i = 0; i < 2; i++) begin
      if (m_hit[i] && m_health[i] > 0) m_health[i]--;
      m_hit[i] = hit_new[i];
    end
    m_lfsr = {m_lfsr[14:0], ^(m_lfsr & 16'hB400)};  // Taps 15, 13, 12, 10
  endfunction

  // ==========================================================================
  // Compare tasks
  // ==========================================================================
  task automatic check_coord(input string what, input coord_t got, input coord_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "Position mismatch");
    end
  endtask

  task automatic check_state(input string what, input player_state_t got,
                             input player_state_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "State mismatch");
    end
  endtask

  task automatic check_health(input string what, input health_t got, input health_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "Health mismatch");
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "Flag mismatch");
    end
  endtask

  task automatic check_outputs();
    check_coord("p1_x", p1_x, coord_t'(m_x[0]));
    check_coord("p2_x", p2_x, coord_t'(m_x[1]));
    check_state("p1_state", p1_state, m_state[0]);
    check_state("p2_state", p2_state, m_state[1]);
    check_health("p1_health", p1_health, health_t'(m_health[0]));
    check_health("p2_health", p2_health, health_t'(m_health[1]));
    check_flag("round_over", round_over, (m_health[0] == 0) || (m_health[1] == 0));
  endtask

  // ==========================================================================
  // Stimulus, driven on the rising edge right after a tick
  // ==========================================================================
  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    {p1_attack, p1_right, p1_left} <= NONE;
    {p2_attack, p2_right, p2_left} <= NONE;
    cpu_mode <= 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;                           // Frame counting starts here
  endtask

  task automatic drive_frames(input int n, input logic [2:0] pad1, input logic [2:0] pad2,
                              input logic cpu);
    repeat (n) begin
      {p1_attack, p1_right, p1_left} <= pad1;
      {p2_attack, p2_right, p2_left} <= pad2;
      cpu_mode <= cpu;
      repeat (`FRAME_DIV) @(posedge clk);    // Ends on the update edge
    end
  endtask

  initial begin : stimulus
    int unsigned r;
    r = $urandom(51);                        // Seed once
    reset = 1'b1;
    cpu_mode = 1'b0;
    {p1_attack, p1_right, p1_left} = NONE;
    {p2_attack, p2_right, p2_left} = NONE;
    apply_reset();
    drive_frames(2, NONE, NONE, 1'b0);
    drive_frames(10, RIGHT, NONE, 1'b0);     // Walk right
    drive_frames(40, LEFT, NONE, 1'b0);      // Into the left wall
    drive_frames(3, BOTH, NONE, 1'b0);       // Opposing directions cancel
    drive_frames(1, ATK, NONE, 1'b0);        // Whiffs far out of range
    drive_frames(12, NONE, NONE, 1'b0);
    drive_frames(1, NONE, ATK, 1'b0);
    drive_frames(12, NONE, NONE, 1'b0);
    drive_frames(55, RIGHT, LEFT, 1'b0);     // Close the gap
    drive_frames(1, NONE, ATK, 1'b0);        // Player 2 lands one on player 1
    drive_frames(11, NONE, NONE, 1'b0);
    repeat (5) begin
      drive_frames(1, ATK, NONE, 1'b0);      // One strike window each
      drive_frames(11, NONE, NONE, 1'b0);
    end
    drive_frames(12, ATK, LEFT | ATK, 1'b0); // Knocked out side ignores the pad
    apply_reset();
    for (int k = 0; k < RANDOM_FRAMES; k++) begin
      r = $urandom;
      drive_frames(1, {r[3] & r[2], r[1], r[0]}, r[6:4], 1'b1);
    end
    stim_done = 1'b1;
  end

  // ==========================================================================
  // Compare process, sampled on falling edges
  // ==========================================================================
  initial begin : compare
    int   cyc;
    logic done;
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (reset !== 1'b0) begin
        model_reset();
        cyc = 0;
      end else begin
        if (cyc == 0) begin
          check_outputs();                   // Values right after reset
        end else if (cyc % `FRAME_DIV == 0) begin
          model_frame(cap_p1, cap_p2, cap_cpu);
          check_outputs();
          if (m_state[0] == ST_HITSTUN) saw_p1_stun = 1'b1;
          if (m_state[1] == ST_HITSTUN) saw_hitstun = 1'b1;
          if (m_state[1] == ST_KO) saw_ko = 1'b1;
          done = stim_done;
        end
        if (cyc % `FRAME_DIV == `FRAME_DIV - 1) begin
          cap_p1  = {p1_attack, p1_right, p1_left};  // Tick comes on the next edge
          cap_p2  = {p2_attack, p2_right, p2_left};
          cap_cpu = cpu_mode;
        end
        cyc++;
      end
    end
    if (!saw_hitstun || !saw_ko || !saw_p1_stun) begin
      $display("Both players were never staggered, or player 2 never knocked out");
      $display("Test failed");
      $fatal(1, "Scenario incomplete");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d clock cycles without finishing the frames", cycle_count);
      $display("Test failed");
      $fatal(1, "Timeout");
    end
  end

endmodule

`default_nettype wire
